//--- source/boardPkg.sv
package boardPkg;

	// Board register slots inside the FE3x page
	typedef enum logic [2:0] {
		regNone,
		regPaging,
		regPrivate,
		regRtcAddr,
		regJumperRead,
		regWpLow,
		regWpHigh,
		regRtcData
	} regSelT;

	// Sideways bank number as written to FE30
	typedef logic [3:0] romBankT;

	// Physical 16K bank inside the 512K RAM chip
	typedef logic [4:0] ramBankT;

	// One write-enable bit per sideways bank, a set bit allows writes
	typedef logic [15:0] wpMaskT;

	// One-hot page of the 128K paged ROM, bit 0 is the base page
	typedef logic [7:0] palPageT;

	// Upper twelve address bits of the board register page
	localparam logic [11:0] regPageBase = 12'hFE3;

	// Top two address bits of the 8000..BFFF sideways window
	localparam logic [1:0] swrTopBits = 2'b10;

	// Screen memory spans 3000..3FFF plus 4000..7FFF
	localparam logic [3:0] screenLowNibble = 4'h3;
	localparam logic [1:0] screenTopBits = 2'b01;

	// Private RAM sits in 8000..AFFF, decoded by top nibble
	localparam logic [3:0] prvNibble8 = 4'h8;
	localparam logic [3:0] prvNibble9 = 4'h9;
	localparam logic [3:0] prvNibbleA = 4'hA;

	// Shadow and private RAM share one 32K block
	localparam ramBankT shadowLowBank = 5'd16;
	localparam ramBankT shadowHighBank = 5'd17;

	// Socket banks start here, below that is motherboard or board RAM
	localparam int socketBankBase = 8;

	// The 128K paged ROM lives in bank 11, pages 1..7 map to banks 25..31
	localparam romBankT palBaseBank = 4'd11;
	localparam ramBankT palExtraBase = 5'd24;

	// Reads in this page switch the paged ROM
	localparam logic [7:0] palZoneBase = 8'hBF;

endpackage

//--- source/busDecode.sv
module busDecode (
	input  logic [15:0]      bbcAddress,
	output boardPkg::regSelT regSel,
	output logic             swrWindow,
	output logic             screenWindow,
	output logic             prv1k,
	output logic             prv4k,
	output logic             prv8k9,
	output logic             prv8kA
);

	// Address bits 0 and 1 only matter for the single-byte registers FE38..FE3B
	always_comb begin
		regSel = boardPkg::regNone;
		if (bbcAddress[15:4] == boardPkg::regPageBase) begin
			case (bbcAddress[3:2])
				2'b00: regSel = boardPkg::regPaging;
				2'b01: regSel = boardPkg::regPrivate;
				2'b10: begin
					case (bbcAddress[1:0])
						2'b00: regSel = boardPkg::regRtcAddr;
						2'b01: regSel = boardPkg::regJumperRead;
						2'b10: regSel = boardPkg::regWpLow;
						default: regSel = boardPkg::regWpHigh;
					endcase
				end
				default: regSel = boardPkg::regRtcData;
			endcase
		end
	end

	// Sideways ROM/RAM window 8000..BFFF
	assign swrWindow = (bbcAddress[15:14] == boardPkg::swrTopBits);

	// Screen memory 3000..7FFF, the part that can be shadowed
	assign screenWindow = (bbcAddress[15:12] == boardPkg::screenLowNibble)
		|| (bbcAddress[15:14] == boardPkg::screenTopBits);

	// 1K private area 8000..83FF
	assign prv1k = (bbcAddress[15:12] == boardPkg::prvNibble8) && (bbcAddress[11:10] == 2'b00);
	// 4K private area 8000..8FFF
	assign prv4k = (bbcAddress[15:12] == boardPkg::prvNibble8);
	// The 8K private area is split in 9000..9FFF and A000..AFFF
	assign prv8k9 = (bbcAddress[15:12] == boardPkg::prvNibble9);
	assign prv8kA = (bbcAddress[15:12] == boardPkg::prvNibbleA);

endmodule

//--- source/pagingRegs.sv
module pagingRegs (
	input  logic              cc4Clk,
	input  logic              bbc_nRST,
	input  logic              cpuPhi1,
	input  logic              cpuRnw,
	input  boardPkg::regSelT  regSel,
	input  logic [7:0]        dataIn,
	input  boardPkg::wpMaskT  ramWriteProt,
	input  logic [7:0]        integraRomSel,
	input  logic [3:0]        beebRomSel,
	output boardPkg::romBankT romBank,
	output logic              privEn,
	output logic              memSel,
	output logic              privS1,
	output logic              privS4,
	output logic              privS8,
	output logic              shadowEn,
	output boardPkg::wpMaskT  wpMask,
	output logic [7:0]        dataOut,
	output logic              dataOe
);

	logic phase2;
	logic regWrite;
	logic regRead;

	// Phase 2 is simply the low half of the CPU phi1 clock
	assign phase2 = !cpuPhi1;
	assign regWrite = phase2 && !cpuRnw;
	assign regRead = phase2 && cpuRnw;

	// Writes are taken on every clock edge of the write phase
	// The CPU holds its data stable, so repeated edges store the same byte
	always_ff @(posedge cc4Clk) begin
		if (!bbc_nRST) begin
			romBank <= '0;
			privEn <= 1'b0;
			memSel <= 1'b0;
			privS1 <= 1'b0;
			privS4 <= 1'b0;
			privS8 <= 1'b0;
			shadowEn <= 1'b0;
			// Jumpers fitted mean protected, so the power-up mask is inverted
			wpMask <= ~ramWriteProt;
		end else if (regWrite) begin
			case (regSel)
				boardPkg::regPaging: begin
					romBank <= dataIn[3:0];
					privEn <= dataIn[6];
					memSel <= dataIn[7];
				end
				boardPkg::regPrivate: begin
					privS8 <= dataIn[4];
					privS4 <= dataIn[5];
					privS1 <= dataIn[6];
					shadowEn <= dataIn[7];
				end
				boardPkg::regWpLow: wpMask[7:0] <= dataIn;
				boardPkg::regWpHigh: wpMask[15:8] <= dataIn;
				default: ;
			endcase
		end
	end

	// Readback for FE38..FE3B, jumper inputs read back inverted
	always_comb begin
		dataOut = 8'h00;
		dataOe = 1'b0;
		case (regSel)
			boardPkg::regRtcAddr: begin
				dataOut = {4'h0, ~beebRomSel};
				dataOe = regRead;
			end
			boardPkg::regJumperRead: begin
				dataOut = ~integraRomSel;
				dataOe = regRead;
			end
			boardPkg::regWpLow: begin
				dataOut = wpMask[7:0];
				dataOe = regRead;
			end
			boardPkg::regWpHigh: begin
				dataOut = wpMask[15:8];
				dataOe = regRead;
			end
			default: ;
		endcase
	end

endmodule

//--- source/bankSelect.sv
module bankSelect (
	input  logic              cpuPhi1,
	input  logic              cpuRnw,
	input  boardPkg::regSelT  regSel,
	input  logic              addrBit14,
	input  logic              swrWindow,
	input  logic              screenWindow,
	input  logic              prv1k,
	input  logic              prv4k,
	input  logic              prv8k9,
	input  logic              prv8kA,
	input  boardPkg::romBankT romBank,
	input  logic              privEn,
	input  logic              memSel,
	input  logic              privS1,
	input  logic              privS4,
	input  logic              privS8,
	input  logic              shadowEn,
	input  boardPkg::wpMaskT  wpMask,
	input  logic [3:0]        beebRomSel,
	input  logic [7:0]        integraRomSel,
	output logic [15:0]       bankHit,
	output logic              shadowSel,
	output logic              ramBankAddrHigh,
	output logic              palRead,
	output logic              toBbcPhi1,
	output logic              toBbcRnw,
	output logic              toBbcRd0,
	output logic              toBbcRd1,
	output logic              nDBufCe,
	output logic              nDBufDir,
	output logic              nRds,
	output logic              nWds,
	output logic              nRomBankSel0to3,
	output logic [7:0]        nRomBankSel,
	output logic              rtcAs,
	output logic              rtcDs
);

	// Socket slot of the paged-ROM bank, counted from the first socket bank
	localparam int palSocket = int'(boardPkg::palBaseBank) - boardPkg::socketBankBase;

	logic phase2;
	logic privAct;
	logic shadowAct;
	logic mbRomBank;
	logic bankDecode;
	logic regAccess;

	assign phase2 = !cpuPhi1;

	// Private RAM needs the global enable and the size bit of its range
	assign privAct = privEn && ((prv1k && privS1) || (prv4k && privS4)
		|| ((prv8k9 || prv8kA) && privS8));
	assign shadowAct = screenWindow && shadowEn && !memSel;
	assign shadowSel = shadowAct || privAct;

	// Private RAM always sits in the lower 16K of the block
	assign ramBankAddrHigh = shadowAct && addrBit14;

	// The current bank is a motherboard ROM when it is 0..3 and jumpered to ROM
	assign mbRomBank = (romBank[3:2] == 2'b00) && beebRomSel[romBank[1:0]];

	// A motherboard ROM is selected for the whole cycle, board banks only in phase 2
	assign bankDecode = swrWindow && !privAct && (phase2 || mbRomBank);
	assign bankHit = bankDecode ? (16'd1 << romBank) : 16'd0;

	assign nRomBankSel0to3 = !(|(bankHit[3:0] & beebRomSel));
	assign nRomBankSel = ~(bankHit[15:8] & integraRomSel);

	// Only reads of the paged-ROM bank while it is mapped to RAM can switch pages
	assign palRead = phase2 && cpuRnw && bankHit[boardPkg::palBaseBank]
		&& !integraRomSel[palSocket];

	// Protection applies per sideways bank, shadow and private RAM are always writable
	assign nWds = !(phase2 && !cpuRnw && ((|(bankHit & wpMask)) || shadowSel));
	assign nRds = !(phase2 && cpuRnw);

	// Hide shadow accesses from the motherboard by holding it in a read of phase 1
	assign toBbcPhi1 = cpuPhi1 || shadowAct;
	assign toBbcRnw = cpuRnw || shadowAct;
	assign toBbcRd0 = romBank[0];
	assign toBbcRd1 = romBank[1];

	assign regAccess = (regSel != boardPkg::regNone);
	assign rtcAs = phase2 && !cpuRnw && (regSel == boardPkg::regRtcAddr);
	assign rtcDs = phase2 && (regSel == boardPkg::regRtcData);

	// The buffer stays off while a motherboard ROM drives the data bus
	assign nDBufCe = !(shadowSel || regAccess || (swrWindow && nRomBankSel0to3));
	assign nDBufDir = cpuRnw;

endmodule

//--- source/ramMapper.sv
module ramMapper (
	input  logic              [15:0] bankHit,
	input  logic              shadowSel,
	input  logic              ramBankAddrHigh,
	input  logic [3:0]        beebRomSel,
	input  logic [7:0]        integraRomSel,
	input  boardPkg::palPageT palPage,
	output logic              nRamCe,
	output logic [4:0]        ramAddress
);

	logic [15:0] ramMapped;
	logic [15:0] ramHit;
	boardPkg::ramBankT swBank;
	boardPkg::ramBankT palBank;

	// Banks 4..7 are always RAM, the rest follow their ROM jumpers
	assign ramMapped = {~integraRomSel, 4'hF, ~beebRomSel};
	assign ramHit = bankHit & ramMapped;

	// Encode the one-hot sideways hit into a bank number
	always_comb begin
		swBank = '0;
		for (int i = 0; i < 16; i++) begin
			if (ramHit[i]) begin
				swBank = boardPkg::ramBankT'(i);
			end
		end
	end

	// Page 0 keeps bank 11, page k moves to the extra bank 24+k
	always_comb begin
		palBank = boardPkg::ramBankT'(boardPkg::palBaseBank);
		for (int k = 1; k < 8; k++) begin
			if (palPage[k]) begin
				palBank = boardPkg::palExtraBase + boardPkg::ramBankT'(k);
			end
		end
	end

	// Shadow and private RAM win, then the sideways bank if it is RAM
	always_comb begin
		if (shadowSel) begin
			ramAddress = ramBankAddrHigh ? boardPkg::shadowHighBank : boardPkg::shadowLowBank;
		end else if (ramHit[boardPkg::palBaseBank]) begin
			ramAddress = palBank;
		end else begin
			ramAddress = swBank;
		end
	end

	// The RAM chip is enabled for any chosen bank
	assign nRamCe = !(shadowSel || (|ramHit));

endmodule

//--- source/palpromPager.sv
module palpromPager (
	input  logic              cc4Clk,
	input  logic              bbc_nRST,
	input  logic [15:0]       bbcAddress,
	input  logic              palRead,
	output boardPkg::palPageT palPage
);

	logic zonePage;
	logic [2:0] zone;

	// The switching zones are the eight 32-byte blocks of BF00..BFFF
	assign zonePage = (bbcAddress[15:8] == boardPkg::palZoneBase);
	assign zone = bbcAddress[7:5];

	always_ff @(posedge cc4Clk) begin
		if (!bbc_nRST) begin
			palPage <= 8'b0000_0001;
		end else if (palRead && zonePage) begin
			// BFE0..BFFF returns to the base page from anywhere
			if (zone == 3'b111) begin
				palPage <= 8'b0000_0001;
			end else if (palPage[0]) begin
				// BFC0 gives page 1 down to BF00 giving page 7
				palPage <= 8'd1 << (3'd7 - zone);
			end
		end
	end

endmodule

//--- source/integraBoard.sv
module integraBoard (
	input  logic             cc4Clk,
	input  logic             bbc_nRST,
	input  logic             cpuPhi1,
	input  logic             cpuRnw,
	input  logic [15:0]      bbcAddress,
	input  logic [7:0]       dataIn,
	input  boardPkg::wpMaskT ramWriteProt,
	input  logic [7:0]       integraRomSel,
	input  logic [3:0]       beebRomSel,
	output logic [7:0]       dataOut,
	output logic             dataOe,
	output logic             toBbcPhi1,
	output logic             toBbcRnw,
	output logic             toBbcRd0,
	output logic             toBbcRd1,
	output logic             nDBufCe,
	output logic             nDBufDir,
	output logic             nRds,
	output logic             nWds,
	output logic             nRomBankSel0to3,
	output logic [7:0]       nRomBankSel,
	output logic             rtcAs,
	output logic             rtcDs,
	output logic             nRamCe,
	output logic [4:0]       ramAddress
);

	boardPkg::regSelT regSel;
	logic swrWindow;
	logic screenWindow;
	logic prv1k;
	logic prv4k;
	logic prv8k9;
	logic prv8kA;
	boardPkg::romBankT romBank;
	logic privEn;
	logic memSel;
	logic privS1;
	logic privS4;
	logic privS8;
	logic shadowEn;
	boardPkg::wpMaskT wpMask;
	logic [15:0] bankHit;
	logic shadowSel;
	logic ramBankAddrHigh;
	logic palRead;
	boardPkg::palPageT palPage;

	// Address decode feeds both the registers and the bank logic
	busDecode busDecode_i (
		.bbcAddress(bbcAddress), .regSel(regSel), .swrWindow(swrWindow),
		.screenWindow(screenWindow), .prv1k(prv1k), .prv4k(prv4k),
		.prv8k9(prv8k9), .prv8kA(prv8kA)
	);

	pagingRegs pagingRegs_i (
		.cc4Clk(cc4Clk), .bbc_nRST(bbc_nRST), .cpuPhi1(cpuPhi1), .cpuRnw(cpuRnw),
		.regSel(regSel), .dataIn(dataIn), .ramWriteProt(ramWriteProt),
		.integraRomSel(integraRomSel), .beebRomSel(beebRomSel), .romBank(romBank),
		.privEn(privEn), .memSel(memSel), .privS1(privS1), .privS4(privS4),
		.privS8(privS8), .shadowEn(shadowEn), .wpMask(wpMask), .dataOut(dataOut),
		.dataOe(dataOe)
	);

	// Bit 14 picks the upper or lower half of the shadow block
	bankSelect bankSelect_i (
		.cpuPhi1(cpuPhi1), .cpuRnw(cpuRnw), .regSel(regSel), .addrBit14(bbcAddress[14]),
		.swrWindow(swrWindow), .screenWindow(screenWindow), .prv1k(prv1k), .prv4k(prv4k),
		.prv8k9(prv8k9), .prv8kA(prv8kA), .romBank(romBank), .privEn(privEn),
		.memSel(memSel), .privS1(privS1), .privS4(privS4), .privS8(privS8),
		.shadowEn(shadowEn), .wpMask(wpMask), .beebRomSel(beebRomSel),
		.integraRomSel(integraRomSel), .bankHit(bankHit), .shadowSel(shadowSel),
		.ramBankAddrHigh(ramBankAddrHigh), .palRead(palRead), .toBbcPhi1(toBbcPhi1),
		.toBbcRnw(toBbcRnw), .toBbcRd0(toBbcRd0), .toBbcRd1(toBbcRd1),
		.nDBufCe(nDBufCe), .nDBufDir(nDBufDir), .nRds(nRds), .nWds(nWds),
		.nRomBankSel0to3(nRomBankSel0to3), .nRomBankSel(nRomBankSel),
		.rtcAs(rtcAs), .rtcDs(rtcDs)
	);

	ramMapper ramMapper_i (
		.bankHit(bankHit), .shadowSel(shadowSel), .ramBankAddrHigh(ramBankAddrHigh),
		.beebRomSel(beebRomSel), .integraRomSel(integraRomSel), .palPage(palPage),
		.nRamCe(nRamCe), .ramAddress(ramAddress)
	);

	palpromPager palpromPager_i (
		.cc4Clk(cc4Clk), .bbc_nRST(bbc_nRST), .bbcAddress(bbcAddress),
		.palRead(palRead), .palPage(palPage)
	);

endmodule

//--- bench/integraBoard_sva.sv
module integraBoard_sva (
	input logic        cc4Clk,
	input logic        bbc_nRST,
	input logic        cpuPhi1,
	input logic        cpuRnw,
	input logic [15:0] bbcAddress,
	input logic        dataOe,
	input logic [7:0]  nRomBankSel,
	input logic        nRamCe,
	input logic        nRomBankSel0to3
);

	// Count of rule violations, watched by the testbench
	int ruleFailures = 0;

	// The board drives the CPU data bus exactly while the CPU reads FE38..FE3B in phase 2
	property oeOnlyInRead;
		@(posedge cc4Clk) disable iff (!bbc_nRST)
			dataOe == (!cpuPhi1 && cpuRnw && (bbcAddress[15:2] == 14'h3F8E));
	endproperty

	// Two socket ROMs must never fight over the bus
	property oneSocketSelected;
		@(posedge cc4Clk) disable iff (!bbc_nRST)
			$countones(~nRomBankSel) <= 1;
	endproperty

	// Board RAM and a motherboard ROM cannot both answer one access
	property ramNotWithMbRom;
		@(posedge cc4Clk) disable iff (!bbc_nRST)
			!(!nRamCe && !nRomBankSel0to3);
	endproperty

	oeCheck: assert property (oeOnlyInRead) else begin
		$error("dataOe does not follow a phase 2 read of FE38..FE3B");
		ruleFailures++;
	end

	socketCheck: assert property (oneSocketSelected) else begin
		$error("More than one socket ROM select is low");
		ruleFailures++;
	end

	ramRomCheck: assert property (ramNotWithMbRom) else begin
		$error("nRamCe and nRomBankSel0to3 are low together");
		ruleFailures++;
	end

endmodule

// Attach the bus rules to every instance of the board
bind integraBoard integraBoard_sva busRules_i (.*);

//--- bench/integraBoardTb.sv
module integraBoardTb;

	localparam int clkPeriod = 4;
	// Bus cycles run by all tests together
	localparam int busCycles = 95;
	localparam int timeoutTime = busCycles * 8 * clkPeriod * 2;

	// Jumper settings, banks 0 and 2 are motherboard ROM, banks 8 and 9 socket ROM
	localparam logic [3:0] beebJumpers = 4'b0101;
	localparam logic [7:0] socketJumpers = 8'b0000_0011;
	localparam logic [15:0] protectJumpers = 16'h00F0;

	logic cc4Clk;
	logic bbc_nRST;
	logic cpuPhi1;
	logic cpuRnw;
	logic [15:0] bbcAddress;
	logic [7:0] dataIn;
	logic [15:0] ramWriteProt;
	logic [7:0] integraRomSel;
	logic [3:0] beebRomSel;
	logic [7:0] dataOut;
	logic dataOe;
	logic toBbcPhi1;
	logic toBbcRnw;
	logic toBbcRd0;
	logic toBbcRd1;
	logic nDBufCe;
	logic nDBufDir;
	logic nRds;
	logic nWds;
	logic nRomBankSel0to3;
	logic [7:0] nRomBankSel;
	logic rtcAs;
	logic rtcDs;
	logic nRamCe;
	logic [4:0] ramAddress;

	logic [31:0] lcgState = 32'hcd5f_5c0f;
	// Write-enable mask as the testbench expects it to be stored
	logic [15:0] expWp;

	integraBoard integraBoard_i (.*);

	initial begin
		cc4Clk = 1'b0;
		forever #(clkPeriod / 2) cc4Clk = ~cc4Clk;
	end

	initial begin
		#(timeoutTime);
		$display("Watchdog expired before the tests finished");
		$display("Some tests failed");
		$fatal(1, "Timeout");
	end

	// The bus rules end the run as soon as one of them fails
	always @(integraBoard_i.busRules_i.ruleFailures) begin
		if (integraBoard_i.busRules_i.ruleFailures != 0) begin
			$display("A bus rule assertion failed at time %0t", $time);
			$display("Some tests failed");
			$fatal(1, "Bus rule assertions failed");
		end
	end

	function automatic logic [31:0] lcgNext(input logic [31:0] s);
		return s * 32'd1664525 + 32'd1013904223;
	endfunction

	// Random address in 8000..BFFF that stays clear of the BFxx switching page
	function automatic logic [15:0] nextWindowAddr();
		lcgState = lcgNext(lcgState);
		return 16'h8000 | (lcgState[31:16] & 16'h3EFF);
	endfunction

	// Random screen address, upper picks 4000..7FFF instead of 3000..3FFF
	function automatic logic [15:0] nextScreenAddr(input logic upper);
		lcgState = lcgNext(lcgState);
		if (upper) begin
			return 16'h4000 | (lcgState[31:16] & 16'h3FFF);
		end
		return 16'h3000 | (lcgState[31:16] & 16'h0FFF);
	endfunction

	function automatic logic [15:0] nextPrivateAddr();
		lcgState = lcgNext(lcgState);
		return 16'h9000 + (lcgState[31:16] % 16'h2000);
	endfunction

	task automatic checkValue(input string name, input logic [31:0] got,
		input logic [31:0] exp);
		assert (got === exp) else begin
			$display("Mismatch at time %0t: %s is %0h, expected %0h", $time, name, got, exp);
			$display("Some tests failed");
			$fatal(1, "Check of %s failed", name);
		end
	endtask

	// One CPU cycle of phase 1 then phase 2, returning in the middle of phase 2
	// The register write edge is the first edge of the following cycle
	task automatic busCycle(input logic [15:0] addr, input logic rnw, input logic [7:0] data);
		@(posedge cc4Clk);
		#1;
		cpuPhi1 = 1'b1;
		bbcAddress = addr;
		cpuRnw = rnw;
		dataIn = data;
		@(posedge cc4Clk);
		#1;
		cpuPhi1 = 1'b0;
		#1;
	endtask

	// Expected routing of a sideways access to bank n, by the jumper rules
	task automatic expectRouting(input int n);
		if (n < 4 && beebJumpers[n]) begin
			checkValue("nRomBankSel0to3", nRomBankSel0to3, 0);
			checkValue("nRamCe", nRamCe, 1);
			checkValue("nDBufCe", nDBufCe, 1);
		end else if (n >= 8 && socketJumpers[n - 8]) begin
			checkValue("nRomBankSel", nRomBankSel, 8'(~(8'd1 << (n - 8))));
			checkValue("nRamCe", nRamCe, 1);
			checkValue("nDBufCe", nDBufCe, 0);
		end else begin
			checkValue("nRamCe", nRamCe, 0);
			checkValue("ramAddress", ramAddress, n);
			checkValue("nDBufCe", nDBufCe, 0);
		end
	endtask

	initial begin
		bbc_nRST = 1'b0;
		cpuPhi1 = 1'b1;
		cpuRnw = 1'b1;
		bbcAddress = 16'h0000;
		dataIn = 8'h00;
		ramWriteProt = protectJumpers;
		integraRomSel = socketJumpers;
		beebRomSel = beebJumpers;
		repeat (2) @(posedge cc4Clk);
		#1;
		bbc_nRST = 1'b1;

		// Readback of the jumpers and the write-protect mask after reset
		busCycle(16'hFE3A, 1'b1, 8'h00);
		checkValue("dataOe", dataOe, 1);
		checkValue("dataOut", dataOut, 8'(~protectJumpers[7:0]));
		busCycle(16'hFE3B, 1'b1, 8'h00);
		checkValue("dataOut", dataOut, 8'(~protectJumpers[15:8]));
		busCycle(16'hFE39, 1'b1, 8'h00);
		checkValue("dataOut", dataOut, 8'(~socketJumpers));
		busCycle(16'hFE38, 1'b1, 8'h00);
		checkValue("dataOut", dataOut, {4'h0, ~beebJumpers});
		busCycle(16'hFE3A, 1'b0, 8'h5A);
		busCycle(16'hFE3B, 1'b0, 8'hC3);
		busCycle(16'hFE3A, 1'b1, 8'h00);
		checkValue("dataOut", dataOut, 8'h5A);
		busCycle(16'hFE3B, 1'b1, 8'h00);
		checkValue("dataOut", dataOut, 8'hC3);
		expWp = 16'hC35A;

		// Every bank through the FE30 register, read at a random window address
		for (int n = 0; n < 16; n++) begin
			busCycle(16'hFE30, 1'b0, 8'(n));
			busCycle(nextWindowAddr(), 1'b1, 8'h00);
			checkValue("dataOe", dataOe, 0);
			checkValue("nRds", nRds, 0);
			checkValue("nDBufDir", nDBufDir, 1);
			checkValue("toBbcRd0", toBbcRd0, n[0]);
			checkValue("toBbcRd1", toBbcRd1, n[1]);
			expectRouting(n);
		end

		// Writes obey the stored mask bit of their bank
		for (int n = 0; n < 16; n++) begin
			busCycle(16'hFE30, 1'b0, 8'(n));
			busCycle(nextWindowAddr(), 1'b0, 8'h33);
			checkValue("nWds", nWds, !expWp[n]);
			checkValue("nRds", nRds, 1);
			checkValue("nDBufDir", nDBufDir, 0);
		end

		// Shadow screen RAM, the motherboard sees an idle phase 1 read
		// The lower screen part lands in bank 16 and 4000..7FFF in bank 17
		busCycle(16'hFE30, 1'b0, 8'h04);
		busCycle(16'hFE34, 1'b0, 8'h80);
		for (int i = 0; i < 4; i++) begin
			busCycle(nextScreenAddr(i[1]), i[0], 8'h11);
			checkValue("nRamCe", nRamCe, 0);
			checkValue("ramAddress", ramAddress, i[1] ? 17 : 16);
			checkValue("nWds", nWds, i[0]);
			checkValue("nDBufCe", nDBufCe, 0);
			checkValue("toBbcPhi1", toBbcPhi1, 1);
			checkValue("toBbcRnw", toBbcRnw, 1);
		end

		// Private 8K RAM in 9000..AFFF takes the access away from socket ROM bank 8
		busCycle(16'hFE30, 1'b0, 8'h48);
		busCycle(16'hFE34, 1'b0, 8'h10);
		for (int i = 0; i < 3; i++) begin
			busCycle(nextPrivateAddr(), 1'b1, 8'h00);
			checkValue("nRamCe", nRamCe, 0);
			checkValue("ramAddress", ramAddress, bbcAddress[14] ? 17 : 16);
			checkValue("nRomBankSel0to3", nRomBankSel0to3, 1);
			checkValue("nRomBankSel", nRomBankSel, 8'hFF);
		end
		busCycle(16'hFE34, 1'b0, 8'h00);

		// Paged ROM in bank 11, pages switch on the edge after the zone read
		busCycle(16'hFE30, 1'b0, 8'h0B);
		busCycle(16'h8123, 1'b1, 8'h00);
		checkValue("ramAddress", ramAddress, 11);
		busCycle(16'hBFC0, 1'b1, 8'h00);
		checkValue("ramAddress", ramAddress, 11);
		busCycle(16'h8123, 1'b1, 8'h00);
		checkValue("ramAddress", ramAddress, 25);
		busCycle(16'hBF00, 1'b1, 8'h00);
		busCycle(16'h8123, 1'b1, 8'h00);
		checkValue("ramAddress", ramAddress, 25);
		busCycle(16'hBFE0, 1'b1, 8'h00);
		busCycle(16'h8123, 1'b1, 8'h00);
		checkValue("ramAddress", ramAddress, 11);

		// RTC address and data strobes
		busCycle(16'hFE38, 1'b0, 8'h12);
		checkValue("rtcAs", rtcAs, 1);
		checkValue("rtcDs", rtcDs, 0);
		busCycle(16'hFE3D, 1'b1, 8'h00);
		checkValue("rtcDs", rtcDs, 1);
		checkValue("rtcAs", rtcAs, 0);
		busCycle(16'hFE3F, 1'b0, 8'h00);
		checkValue("rtcDs", rtcDs, 1);

		@(posedge cc4Clk);
		#1;
		cpuPhi1 = 1'b1;
		@(posedge cc4Clk);
		if (integraBoard_i.busRules_i.ruleFailures == 0) begin
			$display("All tests passed");
			$finish;
		end else begin
			$display("Some tests failed");
			$fatal(1, "Bus rule assertions failed");
		end
	end

endmodule

//--- project.f
source/boardPkg.sv
source/busDecode.sv
source/pagingRegs.sv
source/bankSelect.sv
source/ramMapper.sv
source/palpromPager.sv
source/integraBoard.sv
bench/integraBoard_sva.sv
bench/integraBoardTb.sv

//--- Bender.yml
package:
  name: integra_board

sources:
  - source/boardPkg.sv
  - source/busDecode.sv
  - source/pagingRegs.sv
  - source/bankSelect.sv
  - source/ramMapper.sv
  - source/palpromPager.sv
  - source/integraBoard.sv
  - target: test
    files:
      - bench/integraBoard_sva.sv
      - bench/integraBoardTb.sv
